// ==== Bender.yml ====
package:
  name: surfaceNormal

sources:
  - vecPkg.sv
  - crossStage.sv
  - normSqStage.sv
  - sqrtStage.sv
  - divideStage.sv
  - surfaceNormal.sv
  - target: test
    files:
      - tbSurfaceNormal.sv

// ==== crossStage.sv ====
// Cross product stage, registers C = A x B in fixed point behind a valid/ready handshake
`timescale 1ns/1ps

module crossStage (
	input  logic                            iClk,
	input  logic                            rst,
	input  logic signed [vecPkg::FIX_W-1:0] aX,
	input  logic signed [vecPkg::FIX_W-1:0] aY,
	input  logic signed [vecPkg::FIX_W-1:0] aZ,
	input  logic signed [vecPkg::FIX_W-1:0] bX,
	input  logic signed [vecPkg::FIX_W-1:0] bY,
	input  logic signed [vecPkg::FIX_W-1:0] bZ,
	input  logic                            inValid,
	output logic                            inReady,
	output logic signed [vecPkg::FIX_W-1:0] cX,
	output logic signed [vecPkg::FIX_W-1:0] cY,
	output logic signed [vecPkg::FIX_W-1:0] cZ,
	output logic                            crossValid,
	input  logic                            crossReady
);

	logic signed [vecPkg::FIX_W-1:0] nextX;
	logic signed [vecPkg::FIX_W-1:0] nextY;
	logic signed [vecPkg::FIX_W-1:0] nextZ;
	logic                            accept;

	// Full product, drop the fraction bits, keep one word
	function automatic logic signed [vecPkg::FIX_W-1:0] fixMul(
		input logic signed [vecPkg::FIX_W-1:0] x,
		input logic signed [vecPkg::FIX_W-1:0] y
	);
		logic signed [2*vecPkg::FIX_W-1:0] full;
		full = x * y;
		return full[vecPkg::FRAC_W +: vecPkg::FIX_W];
	endfunction

	// ------------------------------
	// Products and differences
	// ------------------------------

	// Differences wrap at FIX_W
	assign nextX = fixMul(aY, bZ) - fixMul(aZ, bY);
	assign nextY = fixMul(aZ, bX) - fixMul(aX, bZ);
	assign nextZ = fixMul(aX, bY) - fixMul(aY, bX);

	// ------------------------------
	// Output register
	// ------------------------------

	// Free slot or draining this cycle
	assign inReady = !crossValid || crossReady;
	assign accept = inValid && inReady;

	always_ff @(posedge iClk) begin
		if (rst) begin
			crossValid <= 1'b0;
		end else if (accept) begin
			crossValid <= 1'b1;
		end else if (crossReady) begin
			crossValid <= 1'b0;
		end
	end

	always_ff @(posedge iClk) begin
		if (accept) begin
			cX <= nextX;
			cY <= nextY;
			cZ <= nextZ;
		end
	end

	// Stalled result must not move
	crossHold: assert property (@(posedge iClk) disable iff (rst)
		crossValid && !crossReady |=>
			crossValid && $stable(cX) && $stable(cY) && $stable(cZ))
		else $error("crossStage output changed while stalled");

endmodule

// ==== divideStage.sv ====
// Normalize stage, divides each component by the length and flags a zero-length vector
`timescale 1ns/1ps

module divideStage (
	input  logic                             iClk,
	input  logic                             rst,
	input  logic signed [vecPkg::FIX_W-1:0]  wX,
	input  logic signed [vecPkg::FIX_W-1:0]  wY,
	input  logic signed [vecPkg::FIX_W-1:0]  wZ,
	input  logic        [vecPkg::ROOT_W-1:0] len,
	input  logic                             lenValid,
	output logic                             lenReady,
	output logic signed [vecPkg::FIX_W-1:0]  nX,
	output logic signed [vecPkg::FIX_W-1:0]  nY,
	output logic signed [vecPkg::FIX_W-1:0]  nZ,
	output logic                             degenerate,
	output logic                             outValid,
	input  logic                             outReady
);

	logic accept;
	logic zeroLen;

	// Component scaled up by FRAC_W over the unsigned length
	function automatic logic signed [vecPkg::FIX_W-1:0] scaleDiv(
		input logic signed [vecPkg::FIX_W-1:0] comp,
		input logic        [vecPkg::ROOT_W-1:0] den
	);
		logic signed [vecPkg::FIX_W+vecPkg::FRAC_W-1:0] num;
		logic signed [vecPkg::ROOT_W:0]                 sDen;
		logic signed [vecPkg::FIX_W+vecPkg::FRAC_W-1:0] quo;
		num = comp;
		num = num <<< vecPkg::FRAC_W;
		sDen = {1'b0, den};
		// Signed divide truncates toward zero
		quo = num / sDen;
		return quo[vecPkg::FIX_W-1:0];
	endfunction

	// Inside [-1.0, 1.0]
	function automatic logic inUnit(input logic signed [vecPkg::FIX_W-1:0] x);
		return (x >= -vecPkg::FIX_ONE) && (x <= vecPkg::FIX_ONE);
	endfunction

	// ------------------------------
	// Handshake
	// ------------------------------

	assign lenReady = !outValid || outReady;
	assign accept = lenValid && lenReady;
	assign zeroLen = (len == '0);

	always_ff @(posedge iClk) begin
		if (rst) begin
			outValid <= 1'b0;
		end else if (accept) begin
			outValid <= 1'b1;
		end else if (outReady) begin
			outValid <= 1'b0;
		end
	end

	// ------------------------------
	// Quotients
	// ------------------------------

	always_ff @(posedge iClk) begin
		if (accept) begin
			if (zeroLen) begin
				// No direction to report
				nX <= '0;
				nY <= '0;
				nZ <= '0;
				degenerate <= 1'b1;
			end else begin
				nX <= scaleDiv(wX, len);
				nY <= scaleDiv(wY, len);
				nZ <= scaleDiv(wZ, len);
				degenerate <= 1'b0;
			end
		end
	end

	// Floor root keeps every quotient within one unit
	unitRange: assert property (@(posedge iClk) disable iff (rst)
		outValid && !degenerate |-> inUnit(nX) && inUnit(nY) && inUnit(nZ))
		else $error("divideStage output outside unit range");

endmodule

// ==== normSqStage.sv ====
// Squared length stage, registers the raw sum of squares beside the cross product vector
`timescale 1ns/1ps

module normSqStage (
	input  logic                            iClk,
	input  logic                            rst,
	input  logic signed [vecPkg::FIX_W-1:0] cX,
	input  logic signed [vecPkg::FIX_W-1:0] cY,
	input  logic signed [vecPkg::FIX_W-1:0] cZ,
	input  logic                            crossValid,
	output logic                            crossReady,
	output logic signed [vecPkg::FIX_W-1:0] vX,
	output logic signed [vecPkg::FIX_W-1:0] vY,
	output logic signed [vecPkg::FIX_W-1:0] vZ,
	output logic        [vecPkg::SQ_W-1:0]  sumSq,
	output logic                            sqValid,
	input  logic                            sqReady
);

	logic [vecPkg::SQ_W-1:0] sqX;
	logic [vecPkg::SQ_W-1:0] sqY;
	logic [vecPkg::SQ_W-1:0] sqZ;
	logic [vecPkg::SQ_W-1:0] sumNext;
	logic                    accept;

	// ------------------------------
	// Raw squares, no shift
	// ------------------------------

	// Signed operands, so each square is sign extended then nonnegative
	assign sqX = cX * cX;
	assign sqY = cY * cY;
	assign sqZ = cZ * cZ;

	// 16 fraction bits from here on
	assign sumNext = sqX + sqY + sqZ;

	// ------------------------------
	// Output register
	// ------------------------------

	assign crossReady = !sqValid || sqReady;
	assign accept = crossValid && crossReady;

	always_ff @(posedge iClk) begin
		if (rst) begin
			sqValid <= 1'b0;
		end else if (accept) begin
			sqValid <= 1'b1;
		end else if (sqReady) begin
			sqValid <= 1'b0;
		end
	end

	// Vector rides along unchanged
	always_ff @(posedge iClk) begin
		if (accept) begin
			vX <= cX;
			vY <= cY;
			vZ <= cZ;
			sumSq <= sumNext;
		end
	end

	sqHold: assert property (@(posedge iClk) disable iff (rst)
		sqValid && !sqReady |=>
			sqValid && $stable(sumSq) && $stable(vX) && $stable(vY) && $stable(vZ))
		else $error("normSqStage output changed while stalled");

endmodule

// ==== sqrtStage.sv ====
// Bit-serial restoring square root of the sum of squares, one root bit per cycle
`timescale 1ns/1ps

module sqrtStage (
	input  logic                            iClk,
	input  logic                            rst,
	input  logic signed [vecPkg::FIX_W-1:0] vX,
	input  logic signed [vecPkg::FIX_W-1:0] vY,
	input  logic signed [vecPkg::FIX_W-1:0] vZ,
	input  logic        [vecPkg::SQ_W-1:0]  sumSq,
	input  logic                            sqValid,
	output logic                            sqReady,
	output logic signed [vecPkg::FIX_W-1:0] wX,
	output logic signed [vecPkg::FIX_W-1:0] wY,
	output logic signed [vecPkg::FIX_W-1:0] wZ,
	output logic        [vecPkg::ROOT_W-1:0] len,
	output logic                            lenValid,
	input  logic                            lenReady
);

	logic [vecPkg::SQRT_ST_W-1:0] state;
	logic [vecPkg::STEP_W-1:0]    step;
	logic                         lastStep;
	logic                         accept;

	// Radicand bits still to be consumed, two per step
	logic [vecPkg::SQ_W-1:0]     remLo;
	// Partial remainder never exceeds twice the partial root
	logic [vecPkg::ROOT_W:0]     remHi;
	logic [vecPkg::ROOT_W-1:0]   root;
	logic [vecPkg::ROOT_W+2:0]   shifted;
	logic [vecPkg::ROOT_W+2:0]   trial;
	logic [vecPkg::ROOT_W+2:0]   remNext;
	logic                        fits;

	// Copy of the operand for the bound check
	logic [vecPkg::SQ_W-1:0]     radicand;
	logic [vecPkg::SQ_W-1:0]     lenSq;

	// ------------------------------
	// Handshake
	// ------------------------------

	// New work only when idle or while the result leaves
	assign sqReady = (state == vecPkg::SQRT_IDLE) ||
		((state == vecPkg::SQRT_HOLD) && lenReady);
	assign accept = sqValid && sqReady;
	assign lenValid = (state == vecPkg::SQRT_HOLD);
	assign len = root;

	assign lastStep = (step == vecPkg::STEP_W'(vecPkg::SQRT_STEPS));

	// ------------------------------
	// One shift-and-subtract step
	// ------------------------------

	// Bring down the next two radicand bits
	assign shifted = {remHi, remLo[vecPkg::SQ_W-1 -: 2]};
	// (2r+1)^2 - (2r)^2 = 4r+1
	assign trial = {1'b0, root, 2'b01};
	assign fits = (shifted >= trial);
	assign remNext = fits ? (shifted - trial) : shifted;

	// FSM: idle, run SQRT_STEPS bits plus one, hold for the divider
	always_ff @(posedge iClk) begin
		if (rst) begin
			state <= vecPkg::SQRT_IDLE;
			step <= '0;
		end else begin
			case (state)
				vecPkg::SQRT_IDLE: begin
					if (accept) begin
						state <= vecPkg::SQRT_RUN;
						step <= '0;
					end
				end
				vecPkg::SQRT_RUN: begin
					if (lastStep) begin
						state <= vecPkg::SQRT_HOLD;
					end else begin
						step <= step + 1'b1;
					end
				end
				vecPkg::SQRT_HOLD: begin
					if (accept) begin
						state <= vecPkg::SQRT_RUN;
						step <= '0;
					end else if (lenReady) begin
						state <= vecPkg::SQRT_IDLE;
					end
				end
				default: begin
					state <= vecPkg::SQRT_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge iClk) begin
		if (accept) begin
			remLo <= sumSq;
			remHi <= '0;
			root <= '0;
			radicand <= sumSq;
			wX <= vX;
			wY <= vY;
			wZ <= vZ;
		end else if ((state == vecPkg::SQRT_RUN) && !lastStep) begin
			remLo <= {remLo[vecPkg::SQ_W-3:0], 2'b00};
			remHi <= remNext[vecPkg::ROOT_W:0];
			root <= {root[vecPkg::ROOT_W-2:0], fits};
		end
	end

	// Root is a floor, never above the operand
	assign lenSq = len * len;

	rootBound: assert property (@(posedge iClk) disable iff (rst)
		lenValid |-> (lenSq <= radicand))
		else $error("sqrtStage root squared exceeds its operand");

endmodule

// ==== surfaceNormal.f ====
vecPkg.sv
crossStage.sv
normSqStage.sv
sqrtStage.sv
divideStage.sv
surfaceNormal.sv
tbSurfaceNormal.sv

// ==== surfaceNormal.sv ====
// Surface normal pipeline top, cross product to squared length to root to divide
`timescale 1ns/1ps

module surfaceNormal (
	input  logic                            iClk,
	input  logic                            rst,
	input  logic signed [vecPkg::FIX_W-1:0] aX,
	input  logic signed [vecPkg::FIX_W-1:0] aY,
	input  logic signed [vecPkg::FIX_W-1:0] aZ,
	input  logic signed [vecPkg::FIX_W-1:0] bX,
	input  logic signed [vecPkg::FIX_W-1:0] bY,
	input  logic signed [vecPkg::FIX_W-1:0] bZ,
	input  logic                            inValid,
	output logic                            inReady,
	output logic signed [vecPkg::FIX_W-1:0] nX,
	output logic signed [vecPkg::FIX_W-1:0] nY,
	output logic signed [vecPkg::FIX_W-1:0] nZ,
	output logic                            degenerate,
	output logic                            outValid,
	input  logic                            outReady
);

	// Cross product to squared length
	logic signed [vecPkg::FIX_W-1:0]  cX, cY, cZ;
	logic                             crossValid, crossReady;

	// Squared length to root
	logic signed [vecPkg::FIX_W-1:0]  vX, vY, vZ;
	logic        [vecPkg::SQ_W-1:0]   sumSq;
	logic                             sqValid, sqReady;

	// Root to divider
	logic signed [vecPkg::FIX_W-1:0]  wX, wY, wZ;
	logic        [vecPkg::ROOT_W-1:0] len;
	logic                             lenValid, lenReady;

	crossStage uCross (
		.iClk(iClk), .rst(rst),
		.aX(aX), .aY(aY), .aZ(aZ),
		.bX(bX), .bY(bY), .bZ(bZ),
		.inValid(inValid), .inReady(inReady),
		.cX(cX), .cY(cY), .cZ(cZ),
		.crossValid(crossValid), .crossReady(crossReady)
	);

	normSqStage uNormSq (
		.iClk(iClk), .rst(rst),
		.cX(cX), .cY(cY), .cZ(cZ),
		.crossValid(crossValid), .crossReady(crossReady),
		.vX(vX), .vY(vY), .vZ(vZ), .sumSq(sumSq),
		.sqValid(sqValid), .sqReady(sqReady)
	);

	sqrtStage uSqrt (
		.iClk(iClk), .rst(rst),
		.vX(vX), .vY(vY), .vZ(vZ), .sumSq(sumSq),
		.sqValid(sqValid), .sqReady(sqReady),
		.wX(wX), .wY(wY), .wZ(wZ), .len(len),
		.lenValid(lenValid), .lenReady(lenReady)
	);

	divideStage uDivide (
		.iClk(iClk), .rst(rst),
		.wX(wX), .wY(wY), .wZ(wZ), .len(len),
		.lenValid(lenValid), .lenReady(lenReady),
		.nX(nX), .nY(nY), .nZ(nZ), .degenerate(degenerate),
		.outValid(outValid), .outReady(outReady)
	);

endmodule

// ==== tbSurfaceNormal.sv ====
// Testbench for the surface normal pipeline, random and directed vectors against a reference model
`timescale 1ns/1ps

module tbSurfaceNormal;

	localparam int FW = vecPkg::FIX_W;
	localparam int VEC_W = 6 * FW;
	localparam int VEC_COUNT = 200;
	localparam int IN_RANGE = 2048;
	localparam int DRAIN_LIMIT = 20000;
	localparam int STALL_LIMIT = 100;

	logic iClk;
	logic rst;
	logic signed [FW-1:0] aX, aY, aZ, bX, bY, bZ;
	logic inValid, inReady;
	logic signed [FW-1:0] nX, nY, nZ;
	logic degenerate, outValid, outReady;

	integer seed = 32'h00ac_a72b;
	int readyMode;
	int errorCount, checkCount, testCount, inCount, outCount, testErrors;
	bit timedOut, holdPending, inStalled;
	string curTest;
	longint heldX, heldY, heldZ, heldDeg;

	// Pending inputs as {aX, aY, aZ, bX, bY, bZ}, expected results in order
	logic [VEC_W-1:0] srcQ[$];
	logic [VEC_W-1:0] randVecs[VEC_COUNT];
	longint expX[$], expY[$], expZ[$], expDeg[$];

	surfaceNormal uut (
		.iClk(iClk), .rst(rst),
		.aX(aX), .aY(aY), .aZ(aZ), .bX(bX), .bY(bY), .bZ(bZ),
		.inValid(inValid), .inReady(inReady),
		.nX(nX), .nY(nY), .nZ(nZ), .degenerate(degenerate),
		.outValid(outValid), .outReady(outReady)
	);

	initial begin
		iClk = 1'b0;
		forever #50 iClk = ~iClk;
	end

	// ------------------------------
	// Reference model
	// ------------------------------

	// Sign extend the low FW bits
	function automatic longint wrapFix(input longint v);
		logic signed [FW-1:0] t;
		t = v[FW-1:0];
		return t;
	endfunction

	function automatic longint component(input logic [VEC_W-1:0] vec, input int idx);
		logic signed [FW-1:0] t;
		t = vec[idx*FW +: FW];
		return t;
	endfunction

	// Product floored by the fraction bits, kept to one word
	function automatic longint truncProduct(input longint x, input longint y);
		return wrapFix((x * y) >>> vecPkg::FRAC_W);
	endfunction

	function automatic longint floorRoot(input longint s);
		longint r;
		r = longint'($sqrt(real'(s)));
		while (r * r > s) r--;
		while ((r + 1) * (r + 1) <= s) r++;
		return r;
	endfunction

	task automatic modelNormal(input logic [VEC_W-1:0] vec,
		output longint ex, output longint ey, output longint ez, output longint ed);
		longint ax, ay, az, bx, by, bz, cx, cy, cz, s, len;
		ax = component(vec, 5);
		ay = component(vec, 4);
		az = component(vec, 3);
		bx = component(vec, 2);
		by = component(vec, 1);
		bz = component(vec, 0);
		cx = wrapFix(truncProduct(ay, bz) - truncProduct(az, by));
		cy = wrapFix(truncProduct(az, bx) - truncProduct(ax, bz));
		cz = wrapFix(truncProduct(ax, by) - truncProduct(ay, bx));
		s = (cx * cx + cy * cy + cz * cz) & 64'hF_FFFF_FFFF;
		len = floorRoot(s);
		ed = (len == 0);
		ex = (len == 0) ? 0 : wrapFix((cx * 256) / len);
		ey = (len == 0) ? 0 : wrapFix((cy * 256) / len);
		ez = (len == 0) ? 0 : wrapFix((cz * 256) / len);
	endtask

	// ------------------------------
	// Checking and cycle driver
	// ------------------------------

	task automatic checkValue(input string what, input longint expected, input longint actual);
		checkCount++;
		if (expected !== actual) begin
			errorCount++;
			$display("CHECK FAILED %s %s: expected %0d, actual %0d",
				curTest, what, expected, actual);
		end
	endtask

	// Drive at the falling edge, then judge what the next rising edge will transfer
	task automatic runCycle();
		logic [VEC_W-1:0] head;
		longint ex, ey, ez, ed;
		integer rnd;
		@(negedge iClk);
		inValid = (srcQ.size() > 0);
		if (inValid) begin
			head = srcQ[0];
			{aX, aY, aZ, bX, bY, bZ} = head;
		end
		rnd = $random(seed);
		outReady = (readyMode == 0) ? 1'b1 : (readyMode == 1) ? rnd[0] : 1'b0;
		#1;
		if (holdPending) begin
			checkValue("outValid while stalled", 1, outValid);
			checkValue("nX while stalled", heldX, nX);
			checkValue("nY while stalled", heldY, nY);
			checkValue("nZ while stalled", heldZ, nZ);
			checkValue("degenerate while stalled", heldDeg, degenerate);
		end
		holdPending = outValid && !outReady;
		heldX = nX;
		heldY = nY;
		heldZ = nZ;
		heldDeg = degenerate;
		inStalled = inValid && !inReady;
		if (inValid && inReady) begin
			modelNormal(srcQ.pop_front(), ex, ey, ez, ed);
			expX.push_back(ex);
			expY.push_back(ey);
			expZ.push_back(ez);
			expDeg.push_back(ed);
			inCount++;
		end
		if (outValid && outReady) begin
			outCount++;
			if (expX.size() == 0) begin
				errorCount++;
				$display("%s: output appeared with no input pending", curTest);
			end else begin
				checkValue("nX", expX.pop_front(), nX);
				checkValue("nY", expY.pop_front(), nY);
				checkValue("nZ", expZ.pop_front(), nZ);
				checkValue("degenerate", expDeg.pop_front(), degenerate);
			end
		end
	endtask

	task automatic drain(input int limit);
		int cycles;
		cycles = 0;
		while ((srcQ.size() > 0 || expX.size() > 0) && !timedOut) begin
			if (cycles >= limit) begin
				$display("%s: timeout, pipeline did not drain within %0d cycles", curTest, limit);
				timedOut = 1'b1;
				errorCount++;
			end else begin
				runCycle();
				cycles++;
			end
		end
	endtask

	task automatic startTest(input string name);
		curTest = name;
		testErrors = errorCount;
		inCount = 0;
		outCount = 0;
		holdPending = 1'b0;
	endtask

	task automatic finishTest();
		testCount++;
		$display("test %s: %0d in, %0d out, %0d errors",
			curTest, inCount, outCount, errorCount - testErrors);
	endtask

	task automatic directedCase(input string name, input logic [VEC_W-1:0] vec,
		input longint ex, input longint ey, input longint ez, input longint ed);
		longint mx, my, mz, md;
		startTest(name);
		// Model must agree with the hand-worked result
		modelNormal(vec, mx, my, mz, md);
		checkValue("model nX", ex, mx);
		checkValue("model nY", ey, my);
		checkValue("model nZ", ez, mz);
		checkValue("model degenerate", ed, md);
		readyMode = 0;
		srcQ.push_back(vec);
		drain(STALL_LIMIT);
		finishTest();
	endtask

	task automatic randomRun(input string name, input int mode);
		startTest(name);
		readyMode = mode;
		for (int i = 0; i < VEC_COUNT; i++) begin
			srcQ.push_back(randVecs[i]);
		end
		drain(DRAIN_LIMIT);
		checkValue("inputs accepted", VEC_COUNT, inCount);
		checkValue("outputs delivered", inCount, outCount);
		finishTest();
	endtask

	task automatic fillAndDrain();
		int cycles;
		startTest("fill and drain");
		readyMode = 2;
		for (int i = 0; i < 6; i++) begin
			srcQ.push_back(randVecs[i]);
		end
		cycles = 0;
		inStalled = 1'b0;
		// Input blocked while the divider holds an unread result
		while (!(inStalled && outValid) && !timedOut) begin
			if (cycles >= STALL_LIMIT) begin
				$display("%s: timeout, pipeline never filled with outReady low", curTest);
				timedOut = 1'b1;
				errorCount++;
			end else begin
				runCycle();
				cycles++;
			end
		end
		// One register per stage
		checkValue("items held", 4, expX.size());
		readyMode = 0;
		drain(STALL_LIMIT * 4);
		checkValue("outputs delivered", 6, outCount);
		finishTest();
	endtask

	// ------------------------------
	// Test sequence
	// ------------------------------

	initial begin
		rst = 1'b1;
		inValid = 1'b0;
		{aX, aY, aZ, bX, bY, bZ} = '0;
		outReady = 1'b0;
		readyMode = 0;
		for (int i = 0; i < VEC_COUNT; i++) begin
			for (int k = 0; k < 6; k++) begin
				randVecs[i][k*FW +: FW] = FW'($random(seed) % (IN_RANGE + 1));
			end
		end
		repeat (16) @(negedge iClk);
		rst = 1'b0;

		startTest("after reset");
		#1;
		checkValue("outValid", 0, outValid);
		checkValue("inReady", 1, inReady);
		finishTest();

		// Components packed as aX, aY, aZ, bX, bY, bZ
		if (!timedOut) directedCase("x cross y", {18'sd256, 18'sd0, 18'sd0,
			18'sd0, 18'sd256, 18'sd0}, 0, 0, 256, 0);
		if (!timedOut) directedCase("y cross x", {18'sd0, 18'sd256, 18'sd0,
			18'sd256, 18'sd0, 18'sd0}, 0, 0, -256, 0);
		if (!timedOut) directedCase("parallel", {18'sd256, 18'sd512, -18'sd256,
			18'sd512, 18'sd1024, -18'sd512}, 0, 0, 0, 1);
		if (!timedOut) directedCase("zero A", {18'sd0, 18'sd0, 18'sd0,
			18'sd256, 18'sd256, 18'sd256}, 0, 0, 0, 1);
		if (!timedOut) randomRun("random ready high", 0);
		if (!timedOut) randomRun("random ready toggled", 1);
		if (!timedOut) fillAndDrain();

		$display("tests %0d, checks %0d, errors %0d", testCount, checkCount, errorCount);
		if (errorCount == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

// ==== vecPkg.sv ====
// Shared fixed-point widths, square root step count and FSM codes for the normal pipeline
package vecPkg;

	// ------------------------------
	// Fixed-point format
	// ------------------------------

	// One signed component, 8 fraction bits
	localparam int FIX_W = 18;
	localparam int FRAC_W = 8;

	// Raw word for 1.0
	localparam int FIX_ONE = 1 << FRAC_W;

	// Sum of three raw squares, 16 fraction bits
	localparam int SQ_W = 2 * FIX_W;

	// Root of a SQ_W word is back to 8 fraction bits
	localparam int ROOT_W = SQ_W / 2;

	// ------------------------------
	// Square root sequencing
	// ------------------------------

	// One root bit resolved per cycle
	localparam int SQRT_STEPS = ROOT_W;

	// Counter runs 0..SQRT_STEPS inclusive
	localparam int STEP_W = $clog2(SQRT_STEPS + 1);

	// Square root FSM codes
	localparam int SQRT_ST_W = 2;
	localparam logic [SQRT_ST_W-1:0] SQRT_IDLE = 2'd0;
	localparam logic [SQRT_ST_W-1:0] SQRT_RUN = 2'd1;
	// Result parked until the divider takes it
	localparam logic [SQRT_ST_W-1:0] SQRT_HOLD = 2'd2;

endpackage
